/* Makefile */
# Verilator build and run for the narrow/wide router node

VERILATOR ?= verilator
TOP       ?= tb_noc_nw_router
RTL_TOP   ?= noc_nw_router
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= -Wno-fatal
PASS_MSG  ?= Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert -j $(JOBS) $(VFLAGS) \
		-f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/tb_noc_nw_router.sv */
// Testbench for the narrow/wide mesh router node
// Random packet traffic on both planes with credit-keeping senders and sinks
`timescale 1ns/1ps

module tb_noc_nw_router
  import noc_pkg::*;
();

  localparam int BufDepth  = 2;
  localparam int NumPkt    = 12;
  localparam int ProbePort = 3;
  localparam int TotalPkts = 2 * NumPorts * NumPkt + 4;
  localparam int MaxCycles = 40 * TotalPkts + 200;
  localparam coord_t ProbeDst = '{x: 3'd3, y: 3'd2};

  // Expected flit record shared by both planes
  typedef struct packed {
    hdr_t         hdr;
    logic [127:0] pay;
    logic         probe;
    logic [31:0]  cyc;
  } exp_t;

  logic                        clk_i;
  logic                        arst_n_i;
  coord_t                      own;
  narrow_link_t [NumPorts-1:0] narrow_in, narrow_out;
  wide_link_t   [NumPorts-1:0] wide_in, wide_out;
  wire          [NumPorts-1:0] n_vo, w_vo;

  exp_t        sb_q [2][NumPorts][NumPorts][$];
  logic [31:0] rng_state;
  logic [31:0] cyc = '0;
  int          snd_cred [2][NumPorts];
  int          left [2][NumPorts];
  int          pkts [2][NumPorts];
  coord_t      pkt_dst [2][NumPorts];
  int          pend [2][NumPorts];
  logic        hold [2][NumPorts];
  int          acc_cnt [2][NumPorts];
  int          crp_cnt [2][NumPorts];
  int          tx_cnt [2][NumPorts];
  int          cr_cnt [2][NumPorts];
  logic        lock_v [2][NumPorts];
  logic [2:0]  lock_src [2][NumPorts];
  logic        gen_en [2];
  logic        stall_all [2];
  logic        rand_hold;
  int          probe_cnt [2];
  int          probe_done [2];
  int          probe_seen [2];
  int          n_route, n_data, n_worm, n_credit, n_lat, n_other;

  noc_nw_router #(
    .BufDepth ( BufDepth )
  ) dut0 (
    .clk_i,
    .arst_n_i,
    .own_i    ( own        ),
    .narrow_i ( narrow_in  ),
    .narrow_o ( narrow_out ),
    .wide_i   ( wide_in    ),
    .wide_o   ( wide_out   )
  );

  for (genvar i = 0; i < NumPorts; i++) begin : gen_vo
    assign n_vo[i] = narrow_out[i].valid;
    assign w_vo[i] = wide_out[i].valid;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Expected output port number for a destination, X dimension first
  // North 0, East 1, South 2, West 3, Local 4
  function automatic int xy_port(coord_t dst);
    if (dst.x != own.x) begin
      return (dst.x > own.x) ? 1 : 3;
    end
    if (dst.y != own.y) begin
      return (dst.y > own.y) ? 0 : 2;
    end
    return 4;
  endfunction

  function automatic string plane_name(int p);
    return (p == 0) ? "narrow" : "wide";
  endfunction

  function automatic logic credit_out(int p, int i);
    return (p == 0) ? narrow_out[i].credit_v : wide_out[i].credit_v;
  endfunction

  function automatic exp_t sample_out_flit(int p, int o);
    exp_t e;
    e = '0;
    if (p == 0) begin
      e.hdr = narrow_out[o].flit.hdr;
      e.pay = 128'(narrow_out[o].flit.payload);
    end else begin
      e.hdr = wide_out[o].flit.hdr;
      e.pay = wide_out[o].flit.payload;
    end
    return e;
  endfunction

  function automatic int error_total();
    return n_route + n_data + n_worm + n_credit + n_lat + n_other;
  endfunction

  task automatic mismatch(input string sig, input logic [159:0] exp_v, input logic [159:0] act_v);
    $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, sig, exp_v, act_v);
  endtask

  task automatic print_counts();
    $display("Errors: route=%0d data=%0d wormhole=%0d credit=%0d latency=%0d other=%0d",
             n_route, n_data, n_worm, n_credit, n_lat, n_other);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 32'd1;
  end

  initial begin : watchdog
    wait (cyc >= 32'(MaxCycles));
    $display("Timeout after %0d cycles, traffic did not drain", cyc);
    print_counts();
    $display("Result: FAILED");
    $finish;
  end

  // Senders keep a credit count per input and sinks return credits per output
  always @(posedge clk_i) begin : drive_links
    exp_t        e;
    logic [31:0] r;
    logic        fire;
    logic        cv;
    if (arst_n_i) begin
      for (int p = 0; p < 2; p++) begin
        for (int i = 0; i < NumPorts; i++) begin
          r    = next_rand();
          fire = 1'b0;
          e    = '0;
          if (credit_out(p, i)) snd_cred[p][i]++;
          if (snd_cred[p][i] > 0 && left[p][i] == 0) begin
            if (i == ProbePort && probe_cnt[p] != probe_done[p]) begin
              probe_done[p]++;
              fire       = 1'b1;
              e.probe    = 1'b1;
              e.hdr.dst  = ProbeDst;
              e.hdr.last = 1'b1;
            end else if (gen_en[p] && pkts[p][i] < NumPkt && r[31]) begin
              pkts[p][i]++;
              left[p][i]    = 1 + int'(r[29:28]);
              pkt_dst[p][i] = '{x: 3'(1 + r[27:22] % 3), y: 3'(1 + r[21:16] % 3)};
            end
          end
          if (!fire && snd_cred[p][i] > 0 && left[p][i] > 0 && r[30]) begin
            fire = 1'b1;
            left[p][i]--;
            e.hdr.dst  = pkt_dst[p][i];
            e.hdr.last = (left[p][i] == 0);
          end
          if (fire) begin
            snd_cred[p][i]--;
            e.hdr.src = '{x: 3'(i), y: 3'(p)};
            e.pay     = {next_rand(), next_rand(), next_rand(), next_rand()};
            if (p == 0) e.pay = {96'b0, e.pay[31:0]};
            e.cyc = cyc;
            sb_q[p][i][xy_port(e.hdr.dst)].push_back(e);
          end
          // Sink side of output i
          if ((p == 0) ? narrow_out[i].valid : wide_out[i].valid) pend[p][i]++;
          if (!rand_hold) begin
            hold[p][i] = 1'b0;
          end else if (r[15:12] == 4'd0) begin
            hold[p][i] = !hold[p][i];
          end
          cv = !stall_all[p] && !hold[p][i] && pend[p][i] > 0;
          if (cv) pend[p][i]--;
          if (p == 0) begin
            narrow_in[i].valid    <= fire;
            narrow_in[i].flit     <= narrow_flit_t'{hdr: e.hdr, payload: e.pay[31:0]};
            narrow_in[i].credit_v <= cv;
          end else begin
            wide_in[i].valid    <= fire;
            wide_in[i].flit     <= wide_flit_t'{hdr: e.hdr, payload: e.pay};
            wide_in[i].credit_v <= cv;
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin : monitor
    exp_t  e;
    exp_t  got;
    int    src;
    string sig;
    if (arst_n_i) begin
      for (int p = 0; p < 2; p++) begin
        for (int o = 0; o < NumPorts; o++) begin
          if ((p == 0) ? narrow_in[o].valid : wide_in[o].valid) acc_cnt[p][o]++;
          if (credit_out(p, o)) crp_cnt[p][o]++;
          cr_cnt[p][o] <= cr_cnt[p][o] +
                          int'((p == 0) ? narrow_in[o].credit_v : wide_in[o].credit_v);
          if ((p == 0) ? n_vo[o] : w_vo[o]) begin
            tx_cnt[p][o] <= tx_cnt[p][o] + 1;
            got = sample_out_flit(p, o);
            src = int'(got.hdr.src.x);
            sig = $sformatf("%s_o[%0d]", plane_name(p), o);
            assert (xy_port(got.hdr.dst) == o) else begin
              n_route++;
              mismatch({sig, " port"}, 160'(xy_port(got.hdr.dst)), 160'(o));
            end
            if (lock_v[p][o]) begin
              assert (src == int'(lock_src[p][o])) else begin
                n_worm++;
                mismatch({sig, ".flit.hdr.src.x"}, 160'(lock_src[p][o]), 160'(src));
              end
            end
            lock_v[p][o]   = !got.hdr.last;
            lock_src[p][o] = got.hdr.src.x;
            if (src >= NumPorts || sb_q[p][src % NumPorts][o].size() == 0) begin
              n_other++;
              $display("Error at %0t ns: %s sent a flit from input %0d that was never sent there",
                       $time, sig, src);
            end else begin
              e = sb_q[p][src][o].pop_front();
              assert (got.hdr == e.hdr) else begin
                n_data++;
                mismatch({sig, ".flit.hdr"}, 160'(e.hdr), 160'(got.hdr));
              end
              assert (got.pay == e.pay) else begin
                n_data++;
                mismatch({sig, ".flit.payload"}, 160'(e.pay), 160'(got.pay));
              end
              if (e.probe) begin
                probe_seen[p]++;
                // Driven at edge c, written at c+1, valid_o set at c+3, seen here at c+4
                assert (cyc - e.cyc == 32'd4) else begin
                  n_lat++;
                  mismatch({sig, ".valid latency"}, 160'd2, 160'(cyc - e.cyc - 32'd2));
                end
              end
            end
          end
        end
      end
    end
  end

  // A flit may only leave on a credit held at reset or returned by the sink
  for (genvar p = 0; p < 2; p++) begin : gen_plane
    for (genvar o = 0; o < NumPorts; o++) begin : gen_out
      credit_window : assert property (@(posedge clk_i) disable iff (!arst_n_i)
          tx_cnt[p][o] + int'((p == 0) ? n_vo[o] : w_vo[o]) <= BufDepth + cr_cnt[p][o])
        else begin
          n_credit++;
          $display("Mismatch at %0t ns: %s_o[%0d].valid expected 0 got 1", $time,
                   plane_name(p), o);
        end
    end
  end

  task automatic fire_probe(input int p);
    @(negedge clk_i);
    probe_cnt[p]++;
    do @(negedge clk_i); while (probe_seen[p] != probe_cnt[p]);
  endtask

  task automatic wait_backed_up(input int p);
    logic full;
    do begin
      @(negedge clk_i);
      full = 1'b0;
      for (int o = 0; o < NumPorts; o++) full |= (pend[p][o] >= BufDepth);
    end while (!full);
  endtask

  task automatic wait_drained(input int p);
    logic busy;
    do begin
      @(negedge clk_i);
      busy = 1'b0;
      for (int i = 0; i < NumPorts; i++) begin
        busy |= left[p][i] != 0 || pend[p][i] != 0 || snd_cred[p][i] != BufDepth;
        for (int o = 0; o < NumPorts; o++) busy |= sb_q[p][i][o].size() != 0;
      end
    end while (busy);
  endtask

  task automatic wait_all_sent();
    logic busy;
    do begin
      @(negedge clk_i);
      busy = 1'b0;
      for (int p = 0; p < 2; p++) begin
        for (int i = 0; i < NumPorts; i++) busy |= pkts[p][i] != NumPkt || left[p][i] != 0;
      end
    end while (busy);
  endtask

  task automatic check_balance();
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < NumPorts; i++) begin
        assert (crp_cnt[p][i] == acc_cnt[p][i]) else begin
          n_credit++;
          mismatch($sformatf("%s_o[%0d].credit_v pulses", plane_name(p), i),
                   160'(acc_cnt[p][i]), 160'(crp_cnt[p][i]));
        end
      end
    end
  endtask

  initial begin
    rng_state = 32'hbbd8_ba85;
    own       = '{x: 3'd2, y: 3'd2};
    arst_n_i  = 1'b0;
    narrow_in = '0;
    wide_in   = '0;
    rand_hold = 1'b0;
    for (int p = 0; p < 2; p++) begin
      gen_en[p]    = 1'b0;
      stall_all[p] = 1'b0;
      for (int i = 0; i < NumPorts; i++) begin
        snd_cred[p][i] = BufDepth;
        hold[p][i]     = 1'b0;
        lock_v[p][i]   = 1'b0;
      end
    end
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    // Idle router on both planes
    fire_probe(0);
    fire_probe(1);
    // Wide plane backed up behind stalled sinks while narrow is probed
    stall_all[1] = 1'b1;
    gen_en[1]    = 1'b1;
    wait_backed_up(1);
    gen_en[1] = 1'b0;
    fire_probe(0);
    stall_all[1] = 1'b0;
    wait_drained(1);
    // And the reverse
    stall_all[0] = 1'b1;
    gen_en[0]    = 1'b1;
    wait_backed_up(0);
    gen_en[0] = 1'b0;
    fire_probe(1);
    stall_all[0] = 1'b0;
    // Remaining random traffic with sink back-pressure
    gen_en[0] = 1'b1;
    gen_en[1] = 1'b1;
    rand_hold = 1'b1;
    wait_all_sent();
    rand_hold = 1'b0;
    wait_drained(0);
    wait_drained(1);
    check_balance();
    print_counts();
    if (error_total() == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* hw/noc_chan_router.sv */
// Five-port router for one link plane
// Input ports, request/grant crossbar and output ports, generic in flit type
`timescale 1ns/1ps

module noc_chan_router
  import noc_pkg::*;
#(
  parameter type flit_t   = narrow_flit_t,
  parameter int  BufDepth = 2
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  coord_t               own_i,
  input  logic  [NumPorts-1:0] valid_i,
  input  flit_t [NumPorts-1:0] flit_i,
  input  logic  [NumPorts-1:0] credit_v_i,
  output logic  [NumPorts-1:0] valid_o,
  output flit_t [NumPorts-1:0] flit_o,
  output logic  [NumPorts-1:0] credit_v_o
);

  logic  [NumPorts-1:0] in_req;
  logic  [NumPorts-1:0] in_pop;
  port_e [NumPorts-1:0] in_route;
  flit_t [NumPorts-1:0] in_flit;

  // Indexed [output][input]
  logic [NumPorts-1:0][NumPorts-1:0] out_req;
  logic [NumPorts-1:0][NumPorts-1:0] out_gnt;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_in
    noc_input_port #(
      .flit_t   ( flit_t   ),
      .BufDepth ( BufDepth )
    ) i_in_port (
      .clk_i,
      .arst_n_i,
      .own_i,
      .valid_i    ( valid_i[i]    ),
      .flit_i     ( flit_i[i]     ),
      .pop_i      ( in_pop[i]     ),
      .req_o      ( in_req[i]     ),
      .route_o    ( in_route[i]   ),
      .flit_o     ( in_flit[i]    ),
      .credit_v_o ( credit_v_o[i] )
    );
  end

  // Steer each request to the output its route names
  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        out_req[o][i] = in_req[i] && (in_route[i] == port_e'(o));
      end
    end
  end

  // Collect the grants back as pops
  always_comb begin
    in_pop = '0;
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        in_pop[i] = in_pop[i] | out_gnt[o][i];
      end
    end
  end

  // Every output sees all head flits and muxes the granted one
  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    noc_output_port #(
      .flit_t   ( flit_t   ),
      .BufDepth ( BufDepth )
    ) i_out_port (
      .clk_i,
      .arst_n_i,
      .req_i      ( out_req[o]    ),
      .flit_i     ( in_flit       ),
      .credit_v_i ( credit_v_i[o] ),
      .gnt_o      ( out_gnt[o]    ),
      .valid_o    ( valid_o[o]    ),
      .flit_o     ( flit_o[o]     )
    );
  end

endmodule

/* hw/noc_input_port.sv */
// Router input port
// Buffers incoming flits, computes the XY route of each head flit and
// returns one credit upstream for every flit that leaves the buffer
`timescale 1ns/1ps

module noc_input_port
  import noc_pkg::*;
#(
  parameter type flit_t   = narrow_flit_t,
  parameter int  BufDepth = 2
) (
  input  logic   clk_i,
  input  logic   arst_n_i,
  input  coord_t own_i,
  input  logic   valid_i,
  input  flit_t  flit_i,
  input  logic   pop_i,
  output logic   req_o,
  output port_e  route_o,
  output flit_t  flit_o,
  output logic   credit_v_o
);

  localparam int PtrW = (BufDepth > 1) ? $clog2(BufDepth) : 1;
  localparam int CntW = $clog2(BufDepth + 1);

  flit_t           mem_q [BufDepth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            empty;
  flit_t           head;

  port_e route_q;
  logic  route_vld_q;
  logic  credit_q;

  assign empty = (count_q == '0);
  assign head  = mem_q[rd_ptr_q];

  // Flit storage
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      mem_q[wr_ptr_q] <= flit_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(BufDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(BufDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(valid_i) - CntW'(pop_i);
    end
  end

  // Route is latched from the head flit and held for the body of the packet
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      route_q     <= Local;
      route_vld_q <= 1'b0;
      credit_q    <= 1'b0;
    end else begin
      credit_q <= pop_i;
      if (pop_i && head.hdr.last) begin
        route_vld_q <= 1'b0;
      end else if (!empty && !route_vld_q) begin
        route_vld_q <= 1'b1;
        route_q     <= route_xy(own_i, head.hdr.dst);
      end
    end
  end

  assign req_o      = route_vld_q && !empty;
  assign route_o    = route_q;
  assign flit_o     = head;
  assign credit_v_o = credit_q;

endmodule

/* hw/noc_nw_router.sv */
// Narrow/wide mesh router node
// Two independent channel routers, one per link plane, sharing position only
`timescale 1ns/1ps

module noc_nw_router
  import noc_pkg::*;
#(
  parameter int BufDepth = 2
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  coord_t                      own_i,
  input  narrow_link_t [NumPorts-1:0] narrow_i,
  output narrow_link_t [NumPorts-1:0] narrow_o,
  input  wide_link_t   [NumPorts-1:0] wide_i,
  output wide_link_t   [NumPorts-1:0] wide_o
);

  logic         [NumPorts-1:0] n_valid_in, n_valid_out, n_credit_in, n_credit_out;
  narrow_flit_t [NumPorts-1:0] n_flit_in, n_flit_out;
  logic         [NumPorts-1:0] w_valid_in, w_valid_out, w_credit_in, w_credit_out;
  wide_flit_t   [NumPorts-1:0] w_flit_in, w_flit_out;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_links
    assign n_valid_in[i]        = narrow_i[i].valid;
    assign n_flit_in[i]         = narrow_i[i].flit;
    assign n_credit_in[i]       = narrow_i[i].credit_v;
    assign narrow_o[i].valid    = n_valid_out[i];
    assign narrow_o[i].flit     = n_flit_out[i];
    assign narrow_o[i].credit_v = n_credit_out[i];

    assign w_valid_in[i]      = wide_i[i].valid;
    assign w_flit_in[i]       = wide_i[i].flit;
    assign w_credit_in[i]     = wide_i[i].credit_v;
    assign wide_o[i].valid    = w_valid_out[i];
    assign wide_o[i].flit     = w_flit_out[i];
    assign wide_o[i].credit_v = w_credit_out[i];
  end

  noc_chan_router #(
    .flit_t   ( narrow_flit_t ),
    .BufDepth ( BufDepth      )
  ) i_narrow_router (
    .clk_i,
    .arst_n_i,
    .own_i,
    .valid_i    ( n_valid_in   ),
    .flit_i     ( n_flit_in    ),
    .credit_v_i ( n_credit_in  ),
    .valid_o    ( n_valid_out  ),
    .flit_o     ( n_flit_out   ),
    .credit_v_o ( n_credit_out )
  );

  noc_chan_router #(
    .flit_t   ( wide_flit_t ),
    .BufDepth ( BufDepth    )
  ) i_wide_router (
    .clk_i,
    .arst_n_i,
    .own_i,
    .valid_i    ( w_valid_in   ),
    .flit_i     ( w_flit_in    ),
    .credit_v_i ( w_credit_in  ),
    .valid_o    ( w_valid_out  ),
    .flit_o     ( w_flit_out   ),
    .credit_v_o ( w_credit_out )
  );

endmodule

/* hw/noc_output_port.sv */
// Router output port
// Round-robin wormhole arbitration over the five inputs, downstream credit
// tracking and a registered flit output
`timescale 1ns/1ps

module noc_output_port
  import noc_pkg::*;
#(
  parameter type flit_t   = narrow_flit_t,
  parameter int  BufDepth = 2
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic  [NumPorts-1:0] req_i,
  input  flit_t [NumPorts-1:0] flit_i,
  input  logic                 credit_v_i,
  output logic  [NumPorts-1:0] gnt_o,
  output logic                 valid_o,
  output flit_t                flit_o
);

  localparam int CntW = $clog2(BufDepth + 1);

  logic [CntW-1:0] credit_q;
  logic            has_credit;
  logic            locked_q;
  logic [2:0]      lock_idx_q;
  logic [2:0]      rr_q;
  logic [2:0]      pick_idx;
  logic            pick_v;
  logic [2:0]      sel;
  logic            send;
  logic            valid_q;
  flit_t           flit_q;

  assign has_credit = (credit_q != '0);

  // Search starts one past the previous winner and the lowest offset wins
  always_comb begin
    int unsigned idx;
    pick_idx = rr_q;
    pick_v   = 1'b0;
    for (int k = NumPorts; k >= 1; k--) begin
      idx = (int'(rr_q) + k) % NumPorts;
      if (req_i[idx]) begin
        pick_idx = 3'(idx);
        pick_v   = 1'b1;
      end
    end
  end

  always_comb begin
    sel  = lock_idx_q;
    send = 1'b0;
    if (locked_q) begin
      // Held for the packet in flight until its tail is sent
      send = req_i[lock_idx_q] && has_credit;
    end else begin
      sel  = pick_idx;
      send = pick_v && has_credit;
    end
    gnt_o = '0;
    if (send) begin
      gnt_o[sel] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_q   <= CntW'(BufDepth);
      locked_q   <= 1'b0;
      lock_idx_q <= '0;
      rr_q       <= 3'(NumPorts - 1);
      valid_q    <= 1'b0;
    end else begin
      valid_q  <= send;
      credit_q <= credit_q + CntW'(credit_v_i) - CntW'(send);
      if (send) begin
        rr_q       <= sel;
        lock_idx_q <= sel;
        locked_q   <= !flit_i[sel].hdr.last;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (send) begin
      flit_q <= flit_i[sel];
    end
  end

  assign valid_o = valid_q;
  assign flit_o  = flit_q;

endmodule

/* hw/noc_pkg.sv */
// Mesh router shared definitions
// Port directions, coordinates, flit and link structs for the narrow and wide
// planes, plus the dimension-ordered routing function
package noc_pkg;

  // Router ports in link order
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Local = 3'd4
  } port_e;

  localparam int NumPorts = 5;

  localparam int NarrowDataW = 32;
  localparam int WideDataW   = 128;

  // Mesh position of a node
  typedef struct packed {
    logic [2:0] x;
    logic [2:0] y;
  } coord_t;

  // Common flit header where last marks the tail of a packet
  typedef struct packed {
    coord_t dst;
    coord_t src;
    logic   last;
  } hdr_t;

  typedef struct packed {
    hdr_t                   hdr;
    logic [NarrowDataW-1:0] payload;
  } narrow_flit_t;

  typedef struct packed {
    hdr_t                 hdr;
    logic [WideDataW-1:0] payload;
  } wide_flit_t;

  // One link direction with the forward flit and a credit for the reverse one
  typedef struct packed {
    logic         valid;
    narrow_flit_t flit;
    logic         credit_v;
  } narrow_link_t;

  typedef struct packed {
    logic       valid;
    wide_flit_t flit;
    logic       credit_v;
  } wide_link_t;

  // XY routing with the X dimension resolved first
  function automatic port_e route_xy(coord_t own, coord_t dst);
    if (dst.x > own.x) begin
      return East;
    end
    if (dst.x < own.x) begin
      return West;
    end
    if (dst.y > own.y) begin
      return North;
    end
    if (dst.y < own.y) begin
      return South;
    end
    return Local;
  endfunction

endpackage

/* vlog.f */
hw/noc_pkg.sv
hw/noc_input_port.sv
hw/noc_output_port.sv
hw/noc_chan_router.sv
hw/noc_nw_router.sv
bench/tb_noc_nw_router.sv
